//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS = --lint-only --timing --assert --timescale 1ns/10ps -Wall
TOP       = mipsCpuTb
FILELIST  = list.f
BUILDDIR  = obj_dir
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+1000
FAILMSG   = Something failed
PASSMSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- design/alu.sv
// Combinational ALU
// Add, subtract, logic ops, shifts, compares and upper immediate
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  mipsPkg::word    operandA,
    input  mipsPkg::word    operandB,
    input  mipsPkg::regAddr shiftAmount,
    input  mipsPkg::aluOp   op,
    output mipsPkg::word    result
);

    mipsPkg::regAddr distance;

    // Fixed shifts come in on shiftAmount with operandA cleared
    // Variable shifts come in on operandA low bits with shiftAmount cleared
    assign distance = shiftAmount | operandA[mipsPkg::regAddrWidth-1:0];

    always_comb begin
        case (op)
            mipsPkg::aluAdd:  result = operandA + operandB;
            mipsPkg::aluSub:  result = operandA - operandB;
            mipsPkg::aluAnd:  result = operandA & operandB;
            mipsPkg::aluOr:   result = operandA | operandB;
            mipsPkg::aluXor:  result = operandA ^ operandB;
            // Signed compare
            mipsPkg::aluSlt: begin
                result = {31'b0, ($signed(operandA) < $signed(operandB))};
            end
            // Unsigned compare
            mipsPkg::aluSltu: begin
                result = {31'b0, (operandA < operandB)};
            end
            // Shifted value is always operandB
            mipsPkg::aluSll:  result = operandB << distance;
            mipsPkg::aluSrl:  result = operandB >> distance;
            mipsPkg::aluSra:  result = $signed(operandB) >>> distance;
            // Immediate into the upper half
            mipsPkg::aluLui:  result = {operandB[15:0], 16'b0};
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpuControl.sv
// Multicycle control for the MIPS subset
// Fetch/execute/memory/halt FSM, instruction decode and Avalon master signals
`timescale 1ns/10ps
`default_nettype none

module cpuControl (
    input  logic             clk,
    input  logic             reset,
    input  logic             waitrequest,
    input  mipsPkg::word     readdata,
    output mipsPkg::word     address,
    output logic             read,
    output logic             write,
    output mipsPkg::word     writedata,
    output logic [3:0]       byteenable,
    output logic             active,
    regPortIf.control        regs,
    input  mipsPkg::word     pc,
    output mipsPkg::pcSelect pcSel,
    output mipsPkg::word     branchOffset,
    output logic [25:0]      jumpIndex,
    output mipsPkg::word     registerTarget,
    output mipsPkg::word     aluA,
    output mipsPkg::word     aluB,
    output mipsPkg::regAddr  shiftAmount,
    output mipsPkg::aluOp    aluOperation,
    input  mipsPkg::word     aluResult
);

    mipsPkg::cpuState  state;
    mipsPkg::cpuState  stateNext;
    mipsPkg::word      instr;
    mipsPkg::word      memAddr;
    mipsPkg::word      storeData;
    mipsPkg::opcode    opField;
    mipsPkg::functCode fnField;
    mipsPkg::regAddr   rs;
    mipsPkg::regAddr   rt;
    mipsPkg::regAddr   rd;
    mipsPkg::regAddr   shamt;
    mipsPkg::word      immSigned;
    mipsPkg::word      immZero;
    mipsPkg::pcSelect  execSel;
    mipsPkg::word      nextPc;
    logic              isRType;
    logic              writesReg;
    logic              fixedShift;
    logic              zeroExtend;
    logic              isLoad;
    logic              isStore;

    // Instruction fields
    assign opField = mipsPkg::opcode'(instr[31:26]);
    assign fnField = mipsPkg::functCode'(instr[5:0]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign shamt = instr[10:6];
    assign immSigned = {{16{instr[15]}}, instr[15:0]};
    assign immZero = {16'b0, instr[15:0]};
    assign isRType = (opField == mipsPkg::opSpecial);

    // Decode
    always_comb begin
        aluOperation = mipsPkg::aluAdd;
        execSel = mipsPkg::pcAdvance;
        writesReg = 1'b0;
        fixedShift = 1'b0;
        zeroExtend = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        case (opField)
            mipsPkg::opSpecial: begin
                writesReg = 1'b1;
                case (fnField)
                    mipsPkg::fnAddu: aluOperation = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOperation = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOperation = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOperation = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluOperation = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  aluOperation = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: aluOperation = mipsPkg::aluSltu;
                    mipsPkg::fnSll: begin
                        aluOperation = mipsPkg::aluSll;
                        fixedShift = 1'b1;
                    end
                    mipsPkg::fnSrl: begin
                        aluOperation = mipsPkg::aluSrl;
                        fixedShift = 1'b1;
                    end
                    mipsPkg::fnSra: begin
                        aluOperation = mipsPkg::aluSra;
                        fixedShift = 1'b1;
                    end
                    mipsPkg::fnSllv: aluOperation = mipsPkg::aluSll;
                    mipsPkg::fnSrlv: aluOperation = mipsPkg::aluSrl;
                    mipsPkg::fnSrav: aluOperation = mipsPkg::aluSra;
                    // Register jump, no write back
                    mipsPkg::fnJr: begin
                        writesReg = 1'b0;
                        execSel = mipsPkg::pcRegister;
                    end
                    // Unknown function acts as a nop
                    default: writesReg = 1'b0;
                endcase
            end
            mipsPkg::opJ: execSel = mipsPkg::pcJump;
            // Branches resolve in execute
            mipsPkg::opBeq: begin
                if (regs.readDataA == regs.readDataB) begin
                    execSel = mipsPkg::pcBranch;
                end
            end
            mipsPkg::opBne: begin
                if (regs.readDataA != regs.readDataB) begin
                    execSel = mipsPkg::pcBranch;
                end
            end
            mipsPkg::opAddiu: writesReg = 1'b1;
            mipsPkg::opSlti: begin
                writesReg = 1'b1;
                aluOperation = mipsPkg::aluSlt;
            end
            // Sign-extended immediate, compared unsigned
            mipsPkg::opSltiu: begin
                writesReg = 1'b1;
                aluOperation = mipsPkg::aluSltu;
            end
            mipsPkg::opAndi: begin
                writesReg = 1'b1;
                zeroExtend = 1'b1;
                aluOperation = mipsPkg::aluAnd;
            end
            mipsPkg::opOri: begin
                writesReg = 1'b1;
                zeroExtend = 1'b1;
                aluOperation = mipsPkg::aluOr;
            end
            mipsPkg::opXori: begin
                writesReg = 1'b1;
                zeroExtend = 1'b1;
                aluOperation = mipsPkg::aluXor;
            end
            mipsPkg::opLui: begin
                writesReg = 1'b1;
                zeroExtend = 1'b1;
                aluOperation = mipsPkg::aluLui;
            end
            // Address is rs plus signed offset, the default add
            mipsPkg::opLw: isLoad = 1'b1;
            mipsPkg::opSw: isStore = 1'b1;
            default: execSel = mipsPkg::pcAdvance;
        endcase
    end

    // Operand select
    assign regs.readAddrA = rs;
    assign regs.readAddrB = rt;
    assign aluA = fixedShift ? '0 : regs.readDataA;
    assign shiftAmount = fixedShift ? shamt : '0;
    assign aluB = isRType ? regs.readDataB : (zeroExtend ? immZero : immSigned);

    // PC controls
    assign branchOffset = immSigned;
    assign jumpIndex = instr[25:0];
    assign registerTarget = regs.readDataA;

    always_comb begin
        pcSel = mipsPkg::pcHold;
        if ((state == mipsPkg::stateExecute) && !isLoad && !isStore) begin
            pcSel = execSel;
        end else if ((state == mipsPkg::stateMemory) && !waitrequest) begin
            pcSel = mipsPkg::pcAdvance;
        end
    end

    // Same value the PC register takes at the edge
    assign nextPc = mipsPkg::nextPcValue(pc, pcSel, branchOffset, jumpIndex, registerTarget);

    // FSM
    always_comb begin
        stateNext = state;
        case (state)
            mipsPkg::stateFetch: begin
                if (!waitrequest) begin
                    stateNext = mipsPkg::stateExecute;
                end
            end
            mipsPkg::stateExecute: begin
                if (isLoad || isStore) begin
                    stateNext = mipsPkg::stateMemory;
                end else begin
                    // Jump to zero ends the run
                    stateNext = (nextPc == '0) ? mipsPkg::stateHalt : mipsPkg::stateFetch;
                end
            end
            mipsPkg::stateMemory: begin
                if (!waitrequest) begin
                    stateNext = (nextPc == '0) ? mipsPkg::stateHalt : mipsPkg::stateFetch;
                end
            end
            default: stateNext = mipsPkg::stateHalt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::stateFetch;
        end else begin
            state <= stateNext;
        end
    end

    // Instruction latch and load/store operands
    always_ff @(posedge clk) begin
        if ((state == mipsPkg::stateFetch) && !waitrequest) begin
            instr <= readdata;
        end
        if (state == mipsPkg::stateExecute) begin
            memAddr <= aluResult;
            storeData <= regs.readDataB;
        end
    end

    // Write back from ALU in execute, from the bus on load completion
    assign regs.writeEnable = ((state == mipsPkg::stateExecute) && writesReg)
        || ((state == mipsPkg::stateMemory) && isLoad && !waitrequest);
    assign regs.writeAddr = isRType ? rd : rt;
    assign regs.writeData = (state == mipsPkg::stateMemory) ? readdata : aluResult;

    // Avalon master, stable while waitrequest is high
    assign address = (state == mipsPkg::stateMemory) ? memAddr : pc;
    assign read = (state == mipsPkg::stateFetch) || ((state == mipsPkg::stateMemory) && isLoad);
    assign write = (state == mipsPkg::stateMemory) && isStore;
    assign writedata = storeData;
    // Word accesses only
    assign byteenable = 4'b1111;
    assign active = (state != mipsPkg::stateHalt);

endmodule

`default_nettype wire

//--- design/mipsCpuBus.sv
// MIPS subset CPU top level
// Connects control, PC, register file and ALU to an Avalon master port
`timescale 1ns/10ps
`default_nettype none

module mipsCpuBus (
    input  logic         clk,
    input  logic         reset,
    output logic         active,
    output mipsPkg::word register_v0,
    output mipsPkg::word address,
    output logic         write,
    output logic         read,
    input  logic         waitrequest,
    output mipsPkg::word writedata,
    output logic [3:0]   byteenable,
    input  mipsPkg::word readdata
);

    mipsPkg::word     pc;
    mipsPkg::pcSelect pcSel;
    mipsPkg::word     branchOffset;
    logic [25:0]      jumpIndex;
    mipsPkg::word     registerTarget;
    mipsPkg::word     aluA;
    mipsPkg::word     aluB;
    mipsPkg::regAddr  shiftAmount;
    mipsPkg::aluOp    aluOperation;
    mipsPkg::word     aluResult;

    // Register port bundle between control and storage
    regPortIf regBus ();

    registerFile regFile (
        .clk   (clk),
        .reset (reset),
        .regs  (regBus.storage),
        .v0    (register_v0)
    );

    alu mainAlu (
        .operandA    (aluA),
        .operandB    (aluB),
        .shiftAmount (shiftAmount),
        .op          (aluOperation),
        .result      (aluResult)
    );

    programCounter pcReg (
        .clk            (clk),
        .reset          (reset),
        .select         (pcSel),
        .branchOffset   (branchOffset),
        .jumpIndex      (jumpIndex),
        .registerTarget (registerTarget),
        .pc             (pc)
    );

    cpuControl control (
        .clk            (clk),
        .reset          (reset),
        .waitrequest    (waitrequest),
        .readdata       (readdata),
        .address        (address),
        .read           (read),
        .write          (write),
        .writedata      (writedata),
        .byteenable     (byteenable),
        .active         (active),
        .regs           (regBus.control),
        .pc             (pc),
        .pcSel          (pcSel),
        .branchOffset   (branchOffset),
        .jumpIndex      (jumpIndex),
        .registerTarget (registerTarget),
        .aluA           (aluA),
        .aluB           (aluB),
        .shiftAmount    (shiftAmount),
        .aluOperation   (aluOperation),
        .aluResult      (aluResult)
    );

endmodule

`default_nettype wire

//--- design/mipsPkg.sv
// MIPS subset package
// Word and register widths, reset vector, encodings and the next-PC rule
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 32;
    // First fetch address after reset
    localparam logic [dataWidth-1:0] resetVector = 32'hBFC0_0000;

    typedef logic [dataWidth-1:0] word;
    typedef logic [regAddrWidth-1:0] regAddr;

    // Primary opcodes kept in this subset
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJ       = 6'd2,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcode;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functCode;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp;

    // Next-PC sources
    typedef enum logic [2:0] {
        pcHold,
        pcAdvance,
        pcBranch,
        pcJump,
        pcRegister
    } pcSelect;

    typedef enum logic [1:0] {
        stateFetch,
        stateExecute,
        stateMemory,
        stateHalt
    } cpuState;

    // PC after the selected update, no delay slot
    function automatic word nextPcValue(
        input word             pc,
        input pcSelect         select,
        input word             branchOffset,
        input logic [25:0]     jumpIndex,
        input word             registerTarget
    );
        word pcPlus4;
        pcPlus4 = pc + 32'd4;
        case (select)
            pcAdvance:  return pcPlus4;
            // Word offset relative to the following instruction
            pcBranch:   return pcPlus4 + (branchOffset << 2);
            // Region bits come from the incremented PC
            pcJump:     return {pcPlus4[dataWidth-1 -: 4], jumpIndex, 2'b00};
            pcRegister: return registerTarget;
            default:    return pc;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/programCounter.sv
// Program counter register
// Loads the reset vector, then advances, branches, jumps or takes a register target
`timescale 1ns/10ps
`default_nettype none

module programCounter (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::pcSelect select,
    input  mipsPkg::word     branchOffset,
    input  logic [25:0]      jumpIndex,
    input  mipsPkg::word     registerTarget,
    output mipsPkg::word     pc
);

    mipsPkg::word pcTarget;

    // Target for the current select
    // pcHold gives back the current PC
    assign pcTarget = mipsPkg::nextPcValue(
        pc,
        select,
        branchOffset,
        jumpIndex,
        registerTarget
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsPkg::resetVector;
        end else if (select != mipsPkg::pcHold) begin
            // Updates in the same edge the select arrives
            pc <= pcTarget;
        end
    end

endmodule

`default_nettype wire

//--- design/regPortIf.sv
// Register file port bundle
// Two combinational read ports and one clocked write port
`timescale 1ns/10ps
`default_nettype none

interface regPortIf;

    mipsPkg::regAddr readAddrA;
    mipsPkg::regAddr readAddrB;
    mipsPkg::word    readDataA;
    mipsPkg::word    readDataB;
    logic            writeEnable;
    mipsPkg::regAddr writeAddr;
    mipsPkg::word    writeData;

    // Decode side
    modport control (
        output readAddrA, readAddrB, writeEnable, writeAddr, writeData,
        input  readDataA, readDataB
    );

    // Storage side
    modport storage (
        input  readAddrA, readAddrB, writeEnable, writeAddr, writeData,
        output readDataA, readDataB
    );

endinterface

`default_nettype wire

//--- design/registerFile.sv
// General register file, 32 words
// Register zero always reads as zero, v0 is exported for status
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic         clk,
    input  logic         reset,
    regPortIf.storage    regs,
    output mipsPkg::word v0
);

    mipsPkg::word storage [mipsPkg::regCount];

    // Combinational reads
    assign regs.readDataA = storage[regs.readAddrA];
    assign regs.readDataB = storage[regs.readAddrB];

    // Result register v0 is r2
    assign v0 = storage[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mipsPkg::regCount; i++) begin
                storage[i] <= '0;
            end
        end else if (regs.writeEnable && (regs.writeAddr != '0)) begin
            // Writes to r0 are dropped
            storage[regs.writeAddr] <= regs.writeData;
        end
    end

endmodule

`default_nettype wire

//--- list.f
design/mipsPkg.sv
design/regPortIf.sv
design/registerFile.sv
design/alu.sv
design/programCounter.sv
design/cpuControl.sv
design/mipsCpuBus.sv
verification/clockGen.sv
verification/avalonMemory.sv
verification/mipsCpuBus_checker.sv
verification/mipsCpuTb.sv

//--- verification/avalonMemory.sv
// Word-addressed Avalon slave memory model
// Random waitrequest of one to three cycles per transfer, plus a load port
`timescale 1ns/10ps
`default_nettype none

module avalonMemory (
    input  logic         clk,
    input  logic         reset,
    input  mipsPkg::word address,
    input  logic         read,
    input  logic         write,
    input  mipsPkg::word writedata,
    input  logic [3:0]   byteenable,
    output logic         waitrequest,
    output mipsPkg::word readdata,
    input  logic         loadEnable,
    input  logic [9:0]   loadIndex,
    input  mipsPkg::word loadData
);

    localparam int depth = 1024;

    mipsPkg::word mem [depth];
    logic [9:0]   index;
    int           waitLeft;

    // Low address bits pick the word, upper bits alias
    assign index = address[11:2];

    initial begin
        waitrequest = 1'b1;
        readdata = '0;
        waitLeft = 0;
    end

    always @(posedge clk) begin
        // Program loading from the testbench
        if (loadEnable) begin
            mem[loadIndex] <= loadData;
        end
        if (reset) begin
            waitrequest <= 1'b1;
            waitLeft <= $urandom % 3;
        end else if (!waitrequest) begin
            // Transfer completes at this edge
            if (write && (byteenable == 4'b1111)) begin
                mem[index] <= writedata;
            end
            waitrequest <= 1'b1;
            waitLeft <= $urandom % 3;
        end else if (read || write) begin
            if (waitLeft == 0) begin
                // Release and present read data together
                waitrequest <= 1'b0;
                readdata <= mem[index];
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/clockGen.sv
// Testbench clock and reset source
// 20 ns clock, reset held while hold is high and for two cycles after
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    input  logic hold,
    output logic clk,
    output logic reset
);

    int resetLeft;

    initial begin
        clk = 1'b0;
        // Power-on reset lasts two cycles
        resetLeft = 2;
    end

    // Half period 10 ns
    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (hold) begin
            resetLeft <= 2;
        end else if (resetLeft != 0) begin
            resetLeft <= resetLeft - 1;
        end
    end

    assign reset = hold || (resetLeft != 0);

endmodule

`default_nettype wire

//--- verification/mipsCpuBus_checker.sv
// Bus protocol, reset and halt assertions for the CPU
// Bound into every mipsCpuBus instance
`timescale 1ns/10ps
`default_nettype none

module mipsCpuBus_checker (
    input logic         clk,
    input logic         reset,
    input logic         active,
    input logic         read,
    input logic         write,
    input logic         waitrequest,
    input mipsPkg::word address,
    input mipsPkg::word writedata,
    input logic [3:0]   byteenable
);

    // Read by the testbench at the end of the run
    int failCount = 0;

    // Never a read and a write at once
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write high in the same cycle");
            failCount++;
        end

    // Request held while the slave stalls
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else begin
            $error("bus request changed while waitrequest was high");
            failCount++;
        end

    // Word accesses only
    assert property (@(posedge clk) disable iff (reset) byteenable == 4'b1111)
        else begin
            $error("byteenable not all ones");
            failCount++;
        end

    // First cycle out of reset fetches from the reset vector
    assert property (@(posedge clk)
        $fell(reset) |-> read && !write && active && (address == mipsPkg::resetVector))
        else begin
            $error("first fetch after reset is wrong");
            failCount++;
        end

    // Halted CPU stays quiet on the bus
    assert property (@(posedge clk) disable iff (reset) !active |-> !read && !write)
        else begin
            $error("bus activity while halted");
            failCount++;
        end

    // Halt is only left by reset
    assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else begin
            $error("active rose again without reset");
            failCount++;
        end

endmodule

`default_nettype wire

//--- verification/mipsCpuTb.sv
// Testbench for the MIPS subset CPU
// Runs ALU, branch/jump and memory programs and checks v0 after halt
`timescale 1ns/10ps
`default_nettype none

module mipsCpuTb;

    localparam int testCount = 3;
    // Word index of data address 0x804
    localparam int dataIndex = 513;

    logic         clk;
    logic         reset;
    logic         hold;
    logic         active;
    mipsPkg::word v0;
    mipsPkg::word address;
    logic         write;
    logic         read;
    logic         waitrequest;
    mipsPkg::word writedata;
    logic [3:0]   byteenable;
    mipsPkg::word readdata;
    logic         loadEnable;
    logic [9:0]   loadIndex;
    mipsPkg::word loadData;

    mipsPkg::word code[$];
    mipsPkg::word expected;
    int           testsRun;
    int           failures;

    clockGen clocks (
        .hold  (hold),
        .clk   (clk),
        .reset (reset)
    );

    mipsCpuBus DUT (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalonMemory memory (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .loadEnable  (loadEnable),
        .loadIndex   (loadIndex),
        .loadData    (loadData)
    );

    // Protocol assertions inside the DUT
    bind mipsCpuBus mipsCpuBus_checker busCheck (.*);

    // Instruction encoders
    function automatic mipsPkg::word encodeR(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] shamt,
        input logic [5:0] fn
    );
        return {6'b000000, rs, rt, rd, shamt, fn};
    endfunction

    function automatic mipsPkg::word encodeI(
        input logic [5:0]  op,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word encodeJ(input logic [25:0] index);
        return {6'd2, index};
    endfunction

    function automatic mipsPkg::word signExtend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // One operation into r10, folded into v0 by XOR
    task automatic addOp(input mipsPkg::word instr, input mipsPkg::word result);
        code.push_back(instr);
        code.push_back(encodeR(5'd2, 5'd10, 5'd2, 5'd0, mipsPkg::fnXor));
        expected ^= result;
    endtask

    // Load the program under reset, release, wait for halt
    task automatic runProgram();
        @(posedge clk);
        hold <= 1'b1;
        foreach (code[i]) begin
            @(posedge clk);
            loadEnable <= 1'b1;
            loadIndex <= 10'(i);
            loadData <= code[i];
        end
        @(posedge clk);
        loadEnable <= 1'b0;
        hold <= 1'b0;
        @(negedge clk);
        // Watchdog covers a CPU that never halts
        while (reset || active) begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input mipsPkg::word want);
        testsRun++;
        assert (v0 == want) begin
            $display("Test %s done, v0 = %h", name, v0);
        end else begin
            $display("Mismatch in test %s: expected %h, actual %h", name, want, v0);
            failures++;
        end
    endtask

    task automatic testAlu();
        mipsPkg::word a;
        mipsPkg::word b;
        logic [15:0]  imm;
        logic [4:0]   sh;
        a = $urandom;
        b = $urandom;
        imm = 16'($urandom);
        sh = 5'($urandom);
        code.delete();
        expected = '0;
        // r8 = a, r9 = b
        code.push_back(encodeI(mipsPkg::opLui, 5'd0, 5'd8, a[31:16]));
        code.push_back(encodeI(mipsPkg::opOri, 5'd8, 5'd8, a[15:0]));
        code.push_back(encodeI(mipsPkg::opLui, 5'd0, 5'd9, b[31:16]));
        code.push_back(encodeI(mipsPkg::opOri, 5'd9, 5'd9, b[15:0]));
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnAddu), a + b);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSubu), a - b);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnAnd), a & b);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnOr), a | b);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnXor), a ^ b);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSlt),
            mipsPkg::word'($signed(a) < $signed(b)));
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSltu), mipsPkg::word'(a < b));
        // Fixed shifts use shamt, variable ones the low bits of rs
        addOp(encodeR(5'd0, 5'd9, 5'd10, sh, mipsPkg::fnSll), b << sh);
        addOp(encodeR(5'd0, 5'd9, 5'd10, sh, mipsPkg::fnSrl), b >> sh);
        addOp(encodeR(5'd0, 5'd9, 5'd10, sh, mipsPkg::fnSra), $signed(b) >>> sh);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSllv), b << a[4:0]);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSrlv), b >> a[4:0]);
        addOp(encodeR(5'd8, 5'd9, 5'd10, 5'd0, mipsPkg::fnSrav), $signed(b) >>> a[4:0]);
        addOp(encodeI(mipsPkg::opAddiu, 5'd8, 5'd10, imm), a + signExtend(imm));
        addOp(encodeI(mipsPkg::opSlti, 5'd8, 5'd10, imm),
            mipsPkg::word'($signed(a) < $signed(signExtend(imm))));
        // Immediate sign-extended but compared unsigned
        addOp(encodeI(mipsPkg::opSltiu, 5'd8, 5'd10, imm),
            mipsPkg::word'(a < signExtend(imm)));
        addOp(encodeI(mipsPkg::opAndi, 5'd8, 5'd10, imm), a & {16'b0, imm});
        addOp(encodeI(mipsPkg::opOri, 5'd8, 5'd10, imm), a | {16'b0, imm});
        addOp(encodeI(mipsPkg::opXori, 5'd8, 5'd10, imm), a ^ {16'b0, imm});
        addOp(encodeI(mipsPkg::opLui, 5'd0, 5'd10, imm), {imm, 16'b0});
        // jr r0 halts
        code.push_back(encodeR(5'd0, 5'd0, 5'd0, 5'd0, mipsPkg::fnJr));
        runProgram();
        reportTest("alu", expected);
    endtask

    task automatic testBranch();
        int count;
        count = int'($urandom % 20) + 1;
        code.delete();
        code.push_back(encodeI(mipsPkg::opOri, 5'd0, 5'd8, 16'(count)));
        // Loop body at word 1, BNE offset -3 from word 4
        code.push_back(encodeR(5'd2, 5'd8, 5'd2, 5'd0, mipsPkg::fnAddu));
        code.push_back(encodeI(mipsPkg::opAddiu, 5'd8, 5'd8, 16'hFFFF));
        code.push_back(encodeI(mipsPkg::opBne, 5'd8, 5'd0, 16'hFFFD));
        // Taken BEQ skips the poison
        code.push_back(encodeI(mipsPkg::opBeq, 5'd0, 5'd0, 16'd1));
        code.push_back(encodeI(mipsPkg::opAddiu, 5'd2, 5'd2, 16'h0100));
        // J over two more poison words to word 9
        code.push_back(encodeJ(26'((mipsPkg::resetVector + 32'd36) >> 2)));
        code.push_back(encodeI(mipsPkg::opAddiu, 5'd2, 5'd2, 16'h0200));
        code.push_back(encodeI(mipsPkg::opAddiu, 5'd2, 5'd2, 16'h0400));
        code.push_back(encodeR(5'd0, 5'd0, 5'd0, 5'd0, mipsPkg::fnJr));
        runProgram();
        reportTest("branch", mipsPkg::word'(count * (count + 1) / 2));
    endtask

    task automatic testMemory();
        mipsPkg::word value;
        value = $urandom;
        code.delete();
        code.push_back(encodeI(mipsPkg::opLui, 5'd0, 5'd8, value[31:16]));
        code.push_back(encodeI(mipsPkg::opOri, 5'd8, 5'd8, value[15:0]));
        // Base 0x800, offset 4
        code.push_back(encodeI(mipsPkg::opOri, 5'd0, 5'd9, 16'h0800));
        code.push_back(encodeI(mipsPkg::opSw, 5'd9, 5'd8, 16'd4));
        code.push_back(encodeI(mipsPkg::opLw, 5'd9, 5'd2, 16'd4));
        code.push_back(encodeR(5'd0, 5'd0, 5'd0, 5'd0, mipsPkg::fnJr));
        runProgram();
        assert (memory.mem[dataIndex] == value) else begin
            $display("Mismatch in test memory store: expected %h, actual %h",
                value, memory.mem[dataIndex]);
            failures++;
        end
        reportTest("memory", value);
    endtask

    initial begin
        void'($urandom(73));
        hold = 1'b1;
        loadEnable = 1'b0;
        loadIndex = '0;
        loadData = '0;
        testsRun = 0;
        failures = 0;
        testAlu();
        testBranch();
        testMemory();
        $display("Tests run %0d, mismatches %0d, assertion failures %0d",
            testsRun, failures, DUT.busCheck.failCount);
        if ((failures == 0) && (DUT.busCheck.failCount == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Budget of 200 instructions at 8 cycles each per test
    initial begin
        #(testCount * 200 * 8 * 20);
        $display("Timeout, the CPU did not halt in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
